// ==== flist.f ====
verilog/rv_isa_pkg.sv
verilog/core_pkg.sv
verilog/core_if.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/retire_unit.sv
verilog/riscv_core_top.sv
verification/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the core testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=tb_top_sim
log_file=sim.log

verilator --binary --assert -f flist.f --top-module tb_top -Mdir "$build_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "NO ERRORS" "$log_file"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see $log_file"
exit 1

// ==== verification/core_cases.hex ====
// expected retire trace, one record per line
// columns: program pc insn we rd data (data and rd only meaningful when we is 1)
// program 1: register ops, lui, auipc, x0 write, branches, jal, jalr, ecall
00000001 00000000 00500093 1 01 00000005
00000001 00000004 ffd00113 1 02 fffffffd
00000001 00000008 002081b3 1 03 00000002
00000001 0000000c 40208233 1 04 00000008
00000001 00000010 001122b3 1 05 00000001
00000001 00000014 00113333 1 06 00000000
00000001 00000018 0020c3b3 1 07 fffffff8
00000001 0000001c 0020e433 1 08 fffffffd
00000001 00000020 0020f4b3 1 09 00000005
00000001 00000024 00109533 1 0a 000000a0
00000001 00000028 001155b3 1 0b 07ffffff
00000001 0000002c 40115633 1 0c ffffffff
00000001 00000030 123456b7 1 0d 12345000
00000001 00000034 00001717 1 0e 00001034
00000001 00000038 00708013 0 00 0000000c
00000001 0000003c 001007b3 1 0f 00000005
00000001 00000040 00908463 0 00 00000000
00000001 00000048 00909463 0 00 00000000
00000001 0000004c 00114463 0 00 00000000
00000001 00000054 0020d463 0 00 00000000
00000001 0000005c 00116463 0 00 00000000
00000001 00000060 00117463 0 00 00000000
00000001 00000068 0080086f 1 10 0000006c
00000001 00000070 011808e7 1 11 00000074
00000001 0000007c 00000073 0 00 00000000
// program 2: countdown loop, immediate ops, ends on a mul word
00000002 00000000 00200093 1 01 00000002
00000002 00000004 fff08093 1 01 00000001
00000002 00000008 fe009ee3 0 00 00000000
00000002 00000004 fff08093 1 01 00000000
00000002 00000008 fe009ee3 0 00 00000000
00000002 0000000c 0010a113 1 02 00000001
00000002 00000010 fff0b193 1 03 00000001
00000002 00000014 7ff1c213 1 04 000007fe
00000002 00000018 ff006293 1 05 fffffff0
00000002 0000001c 0ff2f313 1 06 000000f0
00000002 00000020 00431393 1 07 00000f00
00000002 00000024 01c2d413 1 08 0000000f
00000002 00000028 4022d493 1 09 fffffffc
00000002 0000002c 02208533 0 00 00000000

// ==== verification/tb_top.sv ====
`timescale 1ns/100ps

// free-running testbench clock
module tb_clock #(
  parameter int period_ns = 20
) (
  output logic clk
);
  initial begin
    clk = 1'b0;
  end

  always begin
    #(period_ns / 2) clk = ~clk;
  end
endmodule

module tb_top;

  localparam int          reset_cycles      = 10;
  localparam int          quiet_cycles      = 20;
  localparam int          cycles_per_record = 60;
  localparam int          fields            = 6;
  localparam int          max_records       = 64;
  localparam int          imem_words        = 256;
  localparam logic [31:0] boot_pc           = 32'h0;

  logic        clk;
  logic        rst;
  logic        imem_req_valid;
  logic        imem_req_ready;
  logic [31:0] imem_addr;
  logic        imem_rsp_valid;
  logic [31:0] imem_insn;
  logic        retire_valid;
  logic        retire_ready;
  logic [31:0] retire_pc;
  logic [31:0] retire_insn;
  logic        retire_we;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;
  logic        halt;

  // six words per record: program, pc, insn, we, rd, data
  logic [31:0] cases [0:fields*max_records-1];
  logic [31:0] imem [0:imem_words-1];
  logic [15:0] lfsr_state;
  int          num_records;
  int          num_programs;
  bit          cases_ready;
  int          error_count;

  tb_clock #(.period_ns(20)) clock_gen (.clk(clk));

  riscv_core_top #(.reset_pc(boot_pc)) dut0 (
    .clk            (clk),
    .rst            (rst),
    .imem_req_valid (imem_req_valid),
    .imem_req_ready (imem_req_ready),
    .imem_addr      (imem_addr),
    .imem_rsp_valid (imem_rsp_valid),
    .imem_insn      (imem_insn),
    .retire_valid   (retire_valid),
    .retire_ready   (retire_ready),
    .retire_pc      (retire_pc),
    .retire_insn    (retire_insn),
    .retire_we      (retire_we),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data),
    .halt           (halt)
  );

  // galois form, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 16'hb400;
    end
    return next;
  endfunction

  task automatic take_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [31:0] case_field(input int rec, input int idx);
    return cases[rec * fields + idx];
  endfunction

  task automatic mismatch(input string name, input logic [31:0] got,
                          input logic [31:0] expected);
    error_count++;
    $display("error at %0d ns: %s is %h, expected %h", $time, name, got, expected);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  task automatic abort_run(input string what);
    error_count++;
    $display("%0d ns: %s", $time, what);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  // unlisted words stay zero, which decodes as illegal
  task automatic load_imem(input int first, input int last);
    logic [31:0] pc;
    for (int i = 0; i < imem_words; i++) begin
      imem[i] = '0;
    end
    for (int r = first; r <= last; r++) begin
      pc = case_field(r, 1);
      imem[pc[9:2]] = case_field(r, 2);
    end
  endtask

  function automatic logic [31:0] imem_word(input logic [31:0] addr);
    if (addr < 32'(imem_words * 4)) begin
      return imem[addr[9:2]];
    end
    return '0;
  endfunction

  task automatic apply_reset();
    rst = 1'b1;
    imem_req_ready = 1'b0;
    imem_rsp_valid = 1'b0;
    imem_insn = '0;
    retire_ready = 1'b0;
    repeat (reset_cycles) begin
      @(posedge clk);
      #1;
      assert (imem_req_valid == 1'b0) else abort_run("imem_req_valid high during reset");
      assert (retire_valid == 1'b0) else abort_run("retire_valid high during reset");
      assert (halt == 1'b0) else abort_run("halt high during reset");
    end
    rst = 1'b0;
    #1;
    assert (imem_req_valid == 1'b1) else abort_run("no imem request right after reset");
    assert (imem_addr == boot_pc) else mismatch("imem_addr", imem_addr, boot_pc);
    assert (retire_valid == 1'b0) else abort_run("retire_valid high right after reset");
    assert (halt == 1'b0) else abort_run("halt high right after reset");
  endtask

  task automatic check_retire(input int rec);
    logic [31:0] exp_we;
    logic [31:0] exp_rd;
    exp_we = case_field(rec, 3);
    exp_rd = case_field(rec, 4);
    assert (retire_pc == case_field(rec, 1))
      else mismatch("retire_pc", retire_pc, case_field(rec, 1));
    assert (retire_insn == case_field(rec, 2))
      else mismatch("retire_insn", retire_insn, case_field(rec, 2));
    assert (retire_we == exp_we[0]) else mismatch("retire_we", {31'd0, retire_we}, exp_we);
    // rd and data only mean something on a register write
    if (exp_we[0]) begin
      assert (retire_rd == exp_rd[4:0]) else mismatch("retire_rd", {27'd0, retire_rd}, exp_rd);
      assert (retire_data == case_field(rec, 5))
        else mismatch("retire_data", retire_data, case_field(rec, 5));
    end
  endtask

  // one program from reset release until the quiet window after halt
  task automatic run_program(input int first, input int last);
    int          rec;
    int          quiet;
    int          delay;
    bit          done;
    bit          rsp_pending;
    bit          stalled;
    logic [31:0] rsp_addr;
    logic [31:0] bits;
    logic [31:0] held_pc;
    logic [31:0] held_insn;
    logic [31:0] held_data;
    logic        held_we;
    logic [4:0]  held_rd;
    rec = first;
    quiet = 0;
    delay = 0;
    rsp_pending = 1'b0;
    stalled = 1'b0;
    rsp_addr = '0;
    while (quiet < quiet_cycles) begin
      @(posedge clk);
      #1;
      done = (rec > last);
      // halt rises the cycle after the final record retires
      assert (halt == done) else mismatch("halt", {31'd0, halt}, {31'd0, done});

      // response is a one-cycle pulse
      imem_rsp_valid = 1'b0;
      imem_insn = '0;
      if (rsp_pending) begin
        if (delay == 0) begin
          imem_rsp_valid = 1'b1;
          imem_insn = imem_word(rsp_addr);
          rsp_pending = 1'b0;
        end else begin
          delay--;
        end
      end

      take_bits(1, bits);
      imem_req_ready = bits[0];
      if (imem_req_valid) begin
        assert (!done) else abort_run("imem request after halt");
        assert (imem_addr == case_field(rec, 1))
          else mismatch("imem_addr", imem_addr, case_field(rec, 1));
        if (imem_req_ready) begin
          rsp_pending = 1'b1;
          rsp_addr = imem_addr;
          take_bits(2, bits);
          delay = int'(bits[1:0]);
        end
      end

      // stalled retire must hold its payload
      if (stalled) begin
        assert (retire_valid) else abort_run("retire_valid dropped while stalled");
        assert (retire_pc == held_pc) else mismatch("retire_pc", retire_pc, held_pc);
        assert (retire_insn == held_insn) else mismatch("retire_insn", retire_insn, held_insn);
        assert (retire_we == held_we)
          else mismatch("retire_we", {31'd0, retire_we}, {31'd0, held_we});
        assert (retire_rd == held_rd)
          else mismatch("retire_rd", {27'd0, retire_rd}, {27'd0, held_rd});
        assert (retire_data == held_data) else mismatch("retire_data", retire_data, held_data);
      end
      take_bits(1, bits);
      retire_ready = bits[0];
      stalled = retire_valid && !retire_ready;
      held_pc = retire_pc;
      held_insn = retire_insn;
      held_we = retire_we;
      held_rd = retire_rd;
      held_data = retire_data;
      if (retire_valid) begin
        assert (!done) else abort_run("retirement after halt");
        if (retire_ready) begin
          check_retire(rec);
          rec++;
        end
      end
      if (done) begin
        quiet++;
      end
    end
  endtask

  // watchdog sized from the record count
  initial begin
    int limit;
    wait (cases_ready);
    limit = num_records * cycles_per_record + num_programs * (reset_cycles + quiet_cycles);
    repeat (limit) @(posedge clk);
    $display("%0d ns: timeout, programs did not finish within %0d cycles", $time, limit);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int first;
    int last;
    rst = 1'b1;
    imem_req_ready = 1'b0;
    imem_rsp_valid = 1'b0;
    imem_insn = '0;
    retire_ready = 1'b0;
    lfsr_state = 16'd28;
    error_count = 0;
    num_records = 0;
    num_programs = 1;
    cases_ready = 1'b0;
    for (int i = 0; i < fields * max_records; i++) begin
      cases[i] = '1;
    end
    $readmemh("verification/core_cases.hex", cases);
    while (num_records < max_records && case_field(num_records, 0) != '1) begin
      num_records++;
    end
    assert (num_records > 0) else abort_run("no records read from verification/core_cases.hex");
    for (int r = 1; r < num_records; r++) begin
      if (case_field(r, 0) != case_field(r - 1, 0)) begin
        num_programs++;
      end
    end
    cases_ready = 1'b1;

    // records of one program sit next to each other
    first = 0;
    while (first < num_records) begin
      last = first;
      while (last + 1 < num_records && case_field(last + 1, 0) == case_field(first, 0)) begin
        last++;
      end
      load_imem(first, last);
      apply_reset();
      run_program(first, last);
      first = last + 1;
    end

    if (error_count == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("ERRORS FOUND");
      $fatal(1, "checks failed");
    end
  end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/100ps

module alu (
  input  rv_isa_pkg::word_t    a,
  input  rv_isa_pkg::word_t    b,
  input  rv_isa_pkg::alu_op_t  op,
  input  rv_isa_pkg::br_cond_t cond,
  output rv_isa_pkg::word_t    result,
  output logic                 taken
);

  logic [4:0] shamt;
  logic       lt_s, lt_u;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (op)
      rv_isa_pkg::alu_add:  result = a + b;
      rv_isa_pkg::alu_sub:  result = a - b;
      rv_isa_pkg::alu_sll:  result = a << shamt;
      rv_isa_pkg::alu_slt:  result = {31'd0, lt_s};
      rv_isa_pkg::alu_sltu: result = {31'd0, lt_u};
      rv_isa_pkg::alu_xor:  result = a ^ b;
      rv_isa_pkg::alu_srl:  result = a >> shamt;
      rv_isa_pkg::alu_sra:  result = $signed(a) >>> shamt;
      rv_isa_pkg::alu_or:   result = a | b;
      rv_isa_pkg::alu_and:  result = a & b;
      default:              result = b;
    endcase
  end

  // branch compare on rs1 against rs2
  always_comb begin
    case (cond)
      rv_isa_pkg::br_beq:  taken = (a == b);
      rv_isa_pkg::br_bne:  taken = (a != b);
      rv_isa_pkg::br_blt:  taken = lt_s;
      rv_isa_pkg::br_bge:  taken = !lt_s;
      rv_isa_pkg::br_bltu: taken = lt_u;
      rv_isa_pkg::br_bgeu: taken = !lt_u;
      default:             taken = 1'b0;
    endcase
  end

endmodule

// ==== verilog/core_if.sv ====
`timescale 1ns/100ps

// fetched instruction handed from fetch to execute
interface fetch_if;
  logic              valid;
  logic              ready;
  rv_isa_pkg::word_t pc;
  rv_isa_pkg::word_t insn;

  modport source (output valid, output pc, output insn, input ready);
  modport sink (input valid, input pc, input insn, output ready);
endinterface

// executed result handed from execute to retire
interface exec_if;
  logic                 valid;
  logic                 ready;
  rv_isa_pkg::word_t    pc;
  rv_isa_pkg::word_t    insn;
  logic                 we;
  rv_isa_pkg::reg_idx_t rd;
  rv_isa_pkg::word_t    data;
  rv_isa_pkg::word_t    next_pc;
  logic                 stop;

  modport source (
    output valid, output pc, output insn, output we, output rd,
    output data, output next_pc, output stop, input ready
  );
  modport sink (
    input valid, input pc, input insn, input we, input rd,
    input data, input next_pc, input stop, output ready
  );
endinterface

// ==== verilog/core_pkg.sv ====
package core_pkg;

  // instruction fetch sequencing
  typedef enum logic [1:0] {
    req,
    wait_rsp,
    hold,
    wait_redirect
  } fetch_state_t;

  // sequential pc step
  parameter int insn_bytes = 4;

endpackage

// ==== verilog/decode_unit.sv ====
`timescale 1ns/100ps

module decode_unit (
  input  rv_isa_pkg::word_t    insn,
  output rv_isa_pkg::decoded_t dec
);

  rv_isa_pkg::opcode_t opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  rv_isa_pkg::word_t   imm_i, imm_b, imm_j, imm_u;
  rv_isa_pkg::alu_op_t reg_op, imm_op;
  logic                reg_f7_ok, imm_f7_ok;

  assign opcode = rv_isa_pkg::opcode_t'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // sign-extended immediates
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    case (funct3)
      rv_isa_pkg::f3_add_sub: reg_op = rv_isa_pkg::alu_add;
      rv_isa_pkg::f3_sll:     reg_op = rv_isa_pkg::alu_sll;
      rv_isa_pkg::f3_slt:     reg_op = rv_isa_pkg::alu_slt;
      rv_isa_pkg::f3_sltu:    reg_op = rv_isa_pkg::alu_sltu;
      rv_isa_pkg::f3_xor:     reg_op = rv_isa_pkg::alu_xor;
      rv_isa_pkg::f3_srl_sra: reg_op = rv_isa_pkg::alu_srl;
      rv_isa_pkg::f3_or:      reg_op = rv_isa_pkg::alu_or;
      default:                reg_op = rv_isa_pkg::alu_and;
    endcase
    imm_op = reg_op;
    // alt funct7 picks sub and sra
    if (funct7 == rv_isa_pkg::f7_alt) begin
      if (funct3 == rv_isa_pkg::f3_add_sub) begin
        reg_op = rv_isa_pkg::alu_sub;
      end else if (funct3 == rv_isa_pkg::f3_srl_sra) begin
        reg_op = rv_isa_pkg::alu_sra;
        imm_op = rv_isa_pkg::alu_sra;
      end
    end
  end

  // M extension uses funct7 = 1 and lands here as illegal
  assign reg_f7_ok = (funct7 == rv_isa_pkg::f7_base) ||
                     (funct7 == rv_isa_pkg::f7_alt &&
                      (funct3 == rv_isa_pkg::f3_add_sub || funct3 == rv_isa_pkg::f3_srl_sra));
  // only shift immediates constrain the upper bits
  assign imm_f7_ok = (funct3 == rv_isa_pkg::f3_sll) ? (funct7 == rv_isa_pkg::f7_base) :
                     (funct3 == rv_isa_pkg::f3_srl_sra) ? reg_f7_ok : 1'b1;

  always_comb begin
    dec         = '0;
    dec.rs1     = insn[19:15];
    dec.rs2     = insn[24:20];
    dec.rd      = insn[11:7];
    dec.alu_op  = rv_isa_pkg::alu_add;
    dec.br_cond = rv_isa_pkg::br_none;
    case (opcode)
      rv_isa_pkg::opc_lui: begin
        dec.imm       = imm_u;
        dec.alu_op    = rv_isa_pkg::alu_pass_b;
        dec.uses_imm  = 1'b1;
        dec.writes_rd = 1'b1;
      end
      rv_isa_pkg::opc_auipc: begin
        dec.imm       = imm_u;
        dec.uses_imm  = 1'b1;
        dec.writes_rd = 1'b1;
        dec.is_auipc  = 1'b1;
      end
      rv_isa_pkg::opc_jal: begin
        dec.imm       = imm_j;
        dec.writes_rd = 1'b1;
        dec.is_jal    = 1'b1;
        dec.link      = 1'b1;
      end
      rv_isa_pkg::opc_jalr: begin
        dec.imm       = imm_i;
        dec.uses_imm  = 1'b1;
        dec.writes_rd = 1'b1;
        dec.is_jalr   = 1'b1;
        dec.link      = 1'b1;
        dec.illegal   = (funct3 != rv_isa_pkg::f3_jalr);
      end
      rv_isa_pkg::opc_branch: begin
        dec.imm = imm_b;
        case (funct3)
          rv_isa_pkg::f3_beq:  dec.br_cond = rv_isa_pkg::br_beq;
          rv_isa_pkg::f3_bne:  dec.br_cond = rv_isa_pkg::br_bne;
          rv_isa_pkg::f3_blt:  dec.br_cond = rv_isa_pkg::br_blt;
          rv_isa_pkg::f3_bge:  dec.br_cond = rv_isa_pkg::br_bge;
          rv_isa_pkg::f3_bltu: dec.br_cond = rv_isa_pkg::br_bltu;
          rv_isa_pkg::f3_bgeu: dec.br_cond = rv_isa_pkg::br_bgeu;
          default:             dec.illegal = 1'b1;
        endcase
      end
      rv_isa_pkg::opc_op_imm: begin
        dec.imm       = imm_i;
        dec.alu_op    = imm_op;
        dec.uses_imm  = 1'b1;
        dec.writes_rd = 1'b1;
        dec.illegal   = !imm_f7_ok;
      end
      rv_isa_pkg::opc_op: begin
        dec.alu_op    = reg_op;
        dec.writes_rd = 1'b1;
        dec.illegal   = !reg_f7_ok;
      end
      rv_isa_pkg::opc_system: begin
        // ecall only, every other field zero
        dec.is_ecall = (insn[31:20] == 12'd0) && (dec.rs1 == 5'd0) &&
                       (funct3 == rv_isa_pkg::f3_priv) && (dec.rd == 5'd0);
        dec.illegal  = !dec.is_ecall;
      end
      default: begin
        // loads, stores, fence and anything unknown
        dec.illegal = 1'b1;
      end
    endcase
  end

endmodule

// ==== verilog/exec_unit.sv ====
`timescale 1ns/100ps

module exec_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_isa_pkg::word_t    rs1_data,
  input  rv_isa_pkg::word_t    rs2_data,
  output rv_isa_pkg::reg_idx_t rs1,
  output rv_isa_pkg::reg_idx_t rs2,
  fetch_if.sink                fetch,
  exec_if.source               exec
);

  rv_isa_pkg::decoded_t dec;
  rv_isa_pkg::word_t    alu_a, alu_b, alu_result;
  rv_isa_pkg::word_t    seq_pc, target_pc, next_pc;
  logic                 taken;
  logic                 stop;
  logic                 accept;
  logic                 valid_q;

  decode_unit u_decode (
    .insn (fetch.insn),
    .dec  (dec)
  );

  assign rs1 = dec.rs1;
  assign rs2 = dec.rs2;

  // auipc adds the immediate to the pc
  assign alu_a = dec.is_auipc ? fetch.pc : rs1_data;
  assign alu_b = dec.uses_imm ? dec.imm : rs2_data;

  alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .op     (dec.alu_op),
    .cond   (dec.br_cond),
    .result (alu_result),
    .taken  (taken)
  );

  assign seq_pc    = fetch.pc + rv_isa_pkg::word_t'(core_pkg::insn_bytes);
  assign target_pc = fetch.pc + dec.imm;

  always_comb begin
    if (dec.is_jalr) begin
      next_pc = {alu_result[rv_isa_pkg::xlen-1:1], 1'b0};
    end else if (dec.is_jal || taken) begin
      next_pc = target_pc;
    end else begin
      next_pc = seq_pc;
    end
  end

  assign stop   = dec.is_ecall | dec.illegal;
  assign accept = fetch.valid & fetch.ready;

  // one result slot
  assign fetch.ready = !valid_q;
  assign exec.valid  = valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (exec.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      exec.pc      <= fetch.pc;
      exec.insn    <= fetch.insn;
      exec.we      <= dec.writes_rd && dec.rd != 5'd0 && !stop;
      exec.rd      <= dec.rd;
      exec.data    <= dec.link ? seq_pc : alu_result;
      exec.next_pc <= next_pc;
      exec.stop    <= stop;
    end
  end

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit #(
  parameter rv_isa_pkg::word_t reset_pc = '0
) (
  input  logic              clk,
  input  logic              rst,
  output logic              imem_req_valid,
  input  logic              imem_req_ready,
  output rv_isa_pkg::word_t imem_addr,
  input  logic              imem_rsp_valid,
  input  rv_isa_pkg::word_t imem_insn,
  input  logic              redirect_valid,
  input  rv_isa_pkg::word_t redirect_pc,
  fetch_if.source           fetch
);

  core_pkg::fetch_state_t state;
  rv_isa_pkg::word_t      pc_q;
  rv_isa_pkg::word_t      insn_q;

  // no request while reset is held
  assign imem_req_valid = (state == core_pkg::req) && !rst;
  assign imem_addr      = pc_q;

  assign fetch.valid = (state == core_pkg::hold);
  assign fetch.pc    = pc_q;
  assign fetch.insn  = insn_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= core_pkg::req;
      pc_q  <= reset_pc;
    end else begin
      case (state)
        core_pkg::req: begin
          if (imem_req_ready) begin
            state <= core_pkg::wait_rsp;
          end
        end
        core_pkg::wait_rsp: begin
          if (imem_rsp_valid) begin
            state <= core_pkg::hold;
          end
        end
        core_pkg::hold: begin
          if (fetch.ready) begin
            state <= core_pkg::wait_redirect;
          end
        end
        default: begin
          // parked here for good once the core halts
          if (redirect_valid) begin
            pc_q  <= redirect_pc;
            state <= core_pkg::req;
          end
        end
      endcase
    end
  end

  // instruction word capture
  always_ff @(posedge clk) begin
    if (state == core_pkg::wait_rsp && imem_rsp_valid) begin
      insn_q <= imem_insn;
    end
  end

  // redirect targets come from execute
  a_addr_aligned: assert property (
    @(posedge clk) disable iff (rst) imem_req_valid |-> imem_addr[1:0] == 2'b00
  ) else $error("misaligned imem request %h", imem_addr);

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  input  rv_isa_pkg::reg_idx_t rd,
  input  logic                 we,
  input  rv_isa_pkg::word_t    wdata,
  output rv_isa_pkg::word_t    rs1_data,
  output rv_isa_pkg::word_t    rs2_data
);

  // x1..x31, x0 has no storage
  rv_isa_pkg::word_t regs [1:31];

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  // execute must already have dropped writes to x0
  a_no_x0_write: assert property (
    @(posedge clk) disable iff (rst) !(we && rd == 5'd0)
  ) else $error("write enable seen for x0");

endmodule

// ==== verilog/retire_unit.sv ====
`timescale 1ns/100ps

module retire_unit (
  input  logic                 clk,
  input  logic                 rst,
  exec_if.sink                 exec,
  output logic                 retire_valid,
  input  logic                 retire_ready,
  output rv_isa_pkg::word_t    retire_pc,
  output rv_isa_pkg::word_t    retire_insn,
  output logic                 retire_we,
  output rv_isa_pkg::reg_idx_t retire_rd,
  output rv_isa_pkg::word_t    retire_data,
  output logic                 rf_we,
  output rv_isa_pkg::reg_idx_t rf_rd,
  output rv_isa_pkg::word_t    rf_wdata,
  output logic                 redirect_valid,
  output rv_isa_pkg::word_t    redirect_pc,
  output logic                 halt
);

  logic fire;

  assign retire_valid = exec.valid;
  assign retire_pc    = exec.pc;
  assign retire_insn  = exec.insn;
  assign retire_we    = exec.we;
  assign retire_rd    = exec.rd;
  assign retire_data  = exec.data;
  assign exec.ready   = retire_ready;

  assign fire = exec.valid & retire_ready;

  // write-back and redirect only on the handshake
  assign rf_we          = fire & exec.we;
  assign rf_rd          = exec.rd;
  assign rf_wdata       = exec.data;
  assign redirect_valid = fire & !exec.stop;
  assign redirect_pc    = exec.next_pc;

  // sticky until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      halt <= 1'b0;
    end else if (fire && exec.stop) begin
      halt <= 1'b1;
    end
  end

  a_retire_stable: assert property (
    @(posedge clk) disable iff (rst)
    retire_valid && !retire_ready |=> retire_valid &&
      $stable({retire_pc, retire_insn, retire_we, retire_rd, retire_data})
  ) else $error("retire payload changed while stalled");

endmodule

// ==== verilog/riscv_core_top.sv ====
`timescale 1ns/100ps

module riscv_core_top #(
  parameter rv_isa_pkg::word_t reset_pc = '0
) (
  input  logic                 clk,
  input  logic                 rst,
  output logic                 imem_req_valid,
  input  logic                 imem_req_ready,
  output rv_isa_pkg::word_t    imem_addr,
  input  logic                 imem_rsp_valid,
  input  rv_isa_pkg::word_t    imem_insn,
  output logic                 retire_valid,
  input  logic                 retire_ready,
  output rv_isa_pkg::word_t    retire_pc,
  output rv_isa_pkg::word_t    retire_insn,
  output logic                 retire_we,
  output rv_isa_pkg::reg_idx_t retire_rd,
  output rv_isa_pkg::word_t    retire_data,
  output logic                 halt
);

  rv_isa_pkg::reg_idx_t rs1, rs2, rf_rd;
  rv_isa_pkg::word_t    rs1_data, rs2_data, rf_wdata, redirect_pc;
  logic                 rf_we;
  logic                 redirect_valid;

  fetch_if fetch_bus ();
  exec_if  exec_bus ();

  fetch_unit #(
    .reset_pc (reset_pc)
  ) u_fetch (
    .clk            (clk),
    .rst            (rst),
    .imem_req_valid (imem_req_valid),
    .imem_req_ready (imem_req_ready),
    .imem_addr      (imem_addr),
    .imem_rsp_valid (imem_rsp_valid),
    .imem_insn      (imem_insn),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .fetch          (fetch_bus.source)
  );

  exec_unit u_exec (
    .clk      (clk),
    .rst      (rst),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .fetch    (fetch_bus.sink),
    .exec     (exec_bus.source)
  );

  reg_file u_regs (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rf_rd),
    .we       (rf_we),
    .wdata    (rf_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  retire_unit u_retire (
    .clk            (clk),
    .rst            (rst),
    .exec           (exec_bus.sink),
    .retire_valid   (retire_valid),
    .retire_ready   (retire_ready),
    .retire_pc      (retire_pc),
    .retire_insn    (retire_insn),
    .retire_we      (retire_we),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data),
    .rf_we          (rf_we),
    .rf_rd          (rf_rd),
    .rf_wdata       (rf_wdata),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .halt           (halt)
  );

endmodule

// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

  parameter int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // major opcodes handled by this core
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_system = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_t;

  typedef enum logic [2:0] {
    br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
  } br_cond_t;

  typedef struct packed {
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    alu_op_t  alu_op;
    br_cond_t br_cond;
    logic     uses_imm;
    logic     writes_rd;
    logic     is_jal;
    logic     is_jalr;
    logic     is_auipc;
    logic     is_ecall;
    logic     illegal;
    logic     link;
  } decoded_t;

  // funct3 for op / op_imm
  parameter logic [2:0] f3_add_sub = 3'b000;
  parameter logic [2:0] f3_sll     = 3'b001;
  parameter logic [2:0] f3_slt     = 3'b010;
  parameter logic [2:0] f3_sltu    = 3'b011;
  parameter logic [2:0] f3_xor     = 3'b100;
  parameter logic [2:0] f3_srl_sra = 3'b101;
  parameter logic [2:0] f3_or      = 3'b110;
  parameter logic [2:0] f3_and     = 3'b111;

  // funct3 for branches
  parameter logic [2:0] f3_beq  = 3'b000;
  parameter logic [2:0] f3_bne  = 3'b001;
  parameter logic [2:0] f3_blt  = 3'b100;
  parameter logic [2:0] f3_bge  = 3'b101;
  parameter logic [2:0] f3_bltu = 3'b110;
  parameter logic [2:0] f3_bgeu = 3'b111;

  parameter logic [2:0] f3_jalr = 3'b000;
  parameter logic [2:0] f3_priv = 3'b000;

  parameter logic [6:0] f7_base = 7'b0000000;
  parameter logic [6:0] f7_alt  = 7'b0100000;

endpackage
